// ==== rtl/board_defs.svh ====
/*
 * Board wrapper constants
 * RTC divider half period and fan PWM period
 * Register bus error value
 * Reset synchronizer depth
 */
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// soc_clk cycles between two rtc edges
`define RTC_HALF_PERIOD 25

// Fan PWM period in soc_clk cycles
`define PWM_PERIOD 15

// Read data for unmapped or illegal register accesses
`define REG_ERR_VAL 32'hBADCAB1E

// Flops in the reset release chain
`define RST_SYNC_STAGES 2

`endif

// ==== rtl/board_reg_pkg.sv ====
/*
 * Register map types of the board control block
 * Address enum, fan and pad configuration words,
 * write word union decoded by address
 */
`default_nettype none

package board_reg_pkg;

  // Address 3 is left unmapped
  typedef enum logic [1:0] {
    ADDR_FAN    = 2'd0,
    ADDR_PAD    = 2'd1,
    ADDR_STATUS = 2'd2
  } reg_addr_e;

  typedef struct packed {
    logic [26:0] rsvd;
    logic        override;
    logic [3:0]  level;
  } fan_cfg_t;

  typedef struct packed {
    logic [29:0] rsvd;
    logic        sd_power_on;
    logic        spi_target;
  } pad_cfg_t;

  // One bus word, seen as fan or pad config by address
  typedef union packed {
    logic [31:0] raw;
    fan_cfg_t    fan;
    pad_cfg_t    pad;
  } reg_wdata_u;

endpackage

`default_nettype wire

// ==== rtl/board_io_pkg.sv ====
/*
 * Pad and fan types
 * SPI target select and fan duty level
 */
`default_nettype none

package board_io_pkg;

  // Device behind the SoC SPI host
  typedef enum logic {
    TARGET_SD    = 1'b0,
    TARGET_FLASH = 1'b1
  } spi_target_e;

  // Fan duty in PWM counter steps
  typedef logic [3:0] fan_level_t;

endpackage

`default_nettype wire

// ==== rtl/board_rstgen.sv ====
/*
 * Board reset generator
 * Async assert, sync release, scan bypass
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module board_rstgen (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic testmode_i,
  output logic sys_rst_n_o
);

  logic [`RST_SYNC_STAGES-1:0] sync_q;

  // Ones shift in after rst_n goes high
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  // Scan drives reset straight from the pin
  assign sys_rst_n_o = testmode_i ? rst_n : sync_q[`RST_SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== rtl/board_rtc_div.sv ====
/*
 * RTC clock divider
 * Toggles rtc_o every RTC_HALF_PERIOD soc_clk cycles
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module board_rtc_div (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  localparam int unsigned CNT_W = $clog2(`RTC_HALF_PERIOD);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RTC_HALF_PERIOD - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             rtc_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (cnt_q == CNT_LAST) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + CNT_W'(1);
    end
  end

  assign rtc_o = rtc_q;

endmodule

`default_nettype wire

// ==== rtl/board_fan_pwm.sv ====
/*
 * Fan PWM controller
 * Level from switches or register override,
 * latched at each period wrap
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module board_fan_pwm (
  input  logic                     soc_clk,
  input  logic                     rst_n,
  input  logic                     override_i,
  input  board_io_pkg::fan_level_t sw_level_i,
  input  board_io_pkg::fan_level_t reg_level_i,
  output logic                     fan_pwm_o,
  output board_io_pkg::fan_level_t level_used_o
);

  import board_io_pkg::*;

  localparam fan_level_t CNT_LAST = fan_level_t'(`PWM_PERIOD - 1);

  fan_level_t cnt_q, cnt_d;
  fan_level_t level_q, level_d;
  logic       pwm_q;

  // New level only at the wrap, so a period is never cut short
  always_comb begin
    cnt_d   = cnt_q + fan_level_t'(1);
    level_d = level_q;
    if (cnt_q == CNT_LAST) begin
      cnt_d   = '0;
      level_d = override_i ? reg_level_i : sw_level_i;
    end
  end

  // Output compare uses next state to stay aligned with cnt_q
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      level_q <= '0;
      pwm_q   <= 1'b0;
    end else begin
      cnt_q   <= cnt_d;
      level_q <= level_d;
      pwm_q   <= (cnt_d < level_d);
    end
  end

  assign fan_pwm_o    = pwm_q;
  assign level_used_o = level_q;

endmodule

`default_nettype wire

// ==== rtl/board_pad_adapt.sv ====
/*
 * SPI pad adapter
 * Routes the SoC SPI host to the SD socket or QSPI flash,
 * idle level 1 on every undriven line
 */
`timescale 1ns/1ps
`default_nettype none

module board_pad_adapt (
  input  logic                      spih_sck_i,
  input  logic                      spih_sck_en_i,
  input  logic                      spih_csb_i,
  input  logic                      spih_csb_en_i,
  input  logic                      spih_sd_i,
  input  logic                      spih_sd_en_i,
  input  logic                      sd_dat0_i,
  input  logic                      qspi_dq0_i,
  input  logic                      sd_power_on_i,
  input  board_io_pkg::spi_target_e spi_target_i,
  output logic                      spih_sd_o,
  output logic                      sd_sclk_o,
  output logic                      sd_cmd_o,
  output logic                      sd_dat3_o,
  output logic                      sd_reset_o,
  output logic                      qspi_clk_o,
  output logic                      qspi_cs_b_o
);

  import board_io_pkg::*;

  logic sel_sd;
  logic sel_flash;

  assign sel_sd    = (spi_target_i == TARGET_SD);
  assign sel_flash = (spi_target_i == TARGET_FLASH);

  ////////////////////////////////////////
  // SD socket in SPI mode
  ////////////////////////////////////////

  assign sd_sclk_o = (sel_sd && spih_sck_en_i) ? spih_sck_i : 1'b1;
  // DAT3 acts as chip select
  assign sd_dat3_o = (sel_sd && spih_csb_en_i) ? spih_csb_i : 1'b1;
  // CMD carries host MOSI
  assign sd_cmd_o  = (sel_sd && spih_sd_en_i) ? spih_sd_i : 1'b1;

  // Reset pin is active high, card unpowered while set
  assign sd_reset_o = ~sd_power_on_i;

  ////////////////////////////////////////
  // QSPI flash
  ////////////////////////////////////////

  assign qspi_clk_o  = (sel_flash && spih_sck_en_i) ? spih_sck_i : 1'b1;
  assign qspi_cs_b_o = (sel_flash && spih_csb_en_i) ? spih_csb_i : 1'b1;

  // MISO back to the host
  assign spih_sd_o = sel_sd ? sd_dat0_i : qspi_dq0_i;

endmodule

`default_nettype wire

// ==== rtl/board_ctrl_regs.sv ====
/*
 * Board control registers on the request-strobe bus
 * Fan and pad configuration, read-only status,
 * error response for unmapped addresses
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module board_ctrl_regs (
  input  logic                      soc_clk,
  input  logic                      rst_n,
  input  logic                      reg_req_i,
  input  logic                      reg_we_i,
  input  board_reg_pkg::reg_addr_e  reg_addr_i,
  input  board_reg_pkg::reg_wdata_u reg_wdata_i,
  input  board_io_pkg::fan_level_t  level_used_i,
  input  logic                      sd_cd_i,
  output logic [31:0]               reg_rdata_o,
  output logic                      reg_err_o,
  output logic                      reg_valid_o,
  output logic                      fan_override_o,
  output board_io_pkg::fan_level_t  fan_level_o,
  output logic                      sd_power_on_o,
  output board_io_pkg::spi_target_e spi_target_o
);

  import board_reg_pkg::*;
  import board_io_pkg::*;

  fan_cfg_t    fan_q;
  pad_cfg_t    pad_q;
  logic        wr_fan;
  logic        wr_pad;
  logic        err_d;
  logic [31:0] rdata_d;
  logic [31:0] status_word;
  logic        valid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  assign wr_fan = reg_req_i && reg_we_i && (reg_addr_i == ADDR_FAN);
  assign wr_pad = reg_req_i && reg_we_i && (reg_addr_i == ADDR_PAD);

  assign status_word = {27'd0, sd_cd_i, level_used_i};

  ////////////////////////////////////////
  // Configuration storage
  ////////////////////////////////////////

  // Only defined fields are written, reserved bits stay zero
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      fan_q            <= '0;
      pad_q            <= '0;
      pad_q.spi_target <= TARGET_SD;
    end else begin
      if (wr_fan) begin
        fan_q.override <= reg_wdata_i.fan.override;
        fan_q.level    <= reg_wdata_i.fan.level;
      end
      if (wr_pad) begin
        pad_q.sd_power_on <= reg_wdata_i.pad.sd_power_on;
        pad_q.spi_target  <= reg_wdata_i.pad.spi_target;
      end
    end
  end

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  always_comb begin
    err_d   = 1'b0;
    rdata_d = '0;
    case (reg_addr_i)
      ADDR_FAN: begin
        if (!reg_we_i) rdata_d = fan_q;
      end
      ADDR_PAD: begin
        if (!reg_we_i) rdata_d = pad_q;
      end
      ADDR_STATUS: begin
        // Status is read-only
        if (reg_we_i) err_d = 1'b1;
        else          rdata_d = status_word;
      end
      default: err_d = 1'b1;
    endcase
    if (err_d) rdata_d = `REG_ERR_VAL;
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      valid_q <= reg_req_i;
      err_q   <= reg_req_i && err_d;
    end
  end

  always_ff @(posedge soc_clk) begin
    if (reg_req_i) rdata_q <= rdata_d;
  end

  assign reg_valid_o = valid_q;
  assign reg_err_o   = err_q;
  assign reg_rdata_o = rdata_q;

  assign fan_override_o = fan_q.override;
  assign fan_level_o    = fan_q.level;
  assign sd_power_on_o  = pad_q.sd_power_on;
  assign spi_target_o   = spi_target_e'(pad_q.spi_target);

endmodule

`default_nettype wire

// ==== rtl/board_top.sv ====
/*
 * FPGA board wrapper top level
 * Reset generator, RTC divider, fan PWM,
 * SPI pad adapter and control registers
 */
`timescale 1ns/1ps
`default_nettype none

module board_top (
  input  logic                     soc_clk,
  input  logic                     rst_n,
  input  logic                     testmode_i,
  // Fan
  input  logic [3:0]               fan_sw_i,
  output logic                     fan_pwm_o,
  // SoC SPI host side
  input  logic                     spih_sck_i,
  input  logic                     spih_sck_en_i,
  input  logic                     spih_csb_i,
  input  logic                     spih_csb_en_i,
  input  logic                     spih_sd_i,
  input  logic                     spih_sd_en_i,
  output logic                     spih_sd_o,
  // SD socket
  input  logic                     sd_cd_i,
  output logic                     sd_sclk_o,
  output logic                     sd_cmd_o,
  output logic                     sd_dat3_o,
  input  logic                     sd_dat0_i,
  output logic                     sd_reset_o,
  // QSPI flash
  output logic                     qspi_clk_o,
  output logic                     qspi_cs_b_o,
  input  logic                     qspi_dq0_i,
  // Register bus
  input  logic                     reg_req_i,
  input  logic                     reg_we_i,
  input  board_reg_pkg::reg_addr_e reg_addr_i,
  input  logic [31:0]              reg_wdata_i,
  output logic [31:0]              reg_rdata_o,
  output logic                     reg_err_o,
  output logic                     reg_valid_o,
  output logic                     rtc_o
);

  import board_io_pkg::*;

  logic        sys_rst_n;
  logic        fan_override;
  fan_level_t  fan_level_reg;
  fan_level_t  level_used;
  logic        sd_power_on;
  spi_target_e spi_target;

  board_rstgen i_rstgen (
    .soc_clk     ( soc_clk    ),
    .rst_n       ( rst_n      ),
    .testmode_i  ( testmode_i ),
    .sys_rst_n_o ( sys_rst_n  )
  );

  board_rtc_div i_rtc_div (
    .soc_clk ( soc_clk   ),
    .rst_n   ( sys_rst_n ),
    .rtc_o   ( rtc_o     )
  );

  board_fan_pwm i_fan_pwm (
    .soc_clk      ( soc_clk       ),
    .rst_n        ( sys_rst_n     ),
    .override_i   ( fan_override  ),
    .sw_level_i   ( fan_sw_i      ),
    .reg_level_i  ( fan_level_reg ),
    .fan_pwm_o    ( fan_pwm_o     ),
    .level_used_o ( level_used    )
  );

  board_pad_adapt i_pad_adapt (
    .spih_sck_i    ( spih_sck_i    ),
    .spih_sck_en_i ( spih_sck_en_i ),
    .spih_csb_i    ( spih_csb_i    ),
    .spih_csb_en_i ( spih_csb_en_i ),
    .spih_sd_i     ( spih_sd_i     ),
    .spih_sd_en_i  ( spih_sd_en_i  ),
    .sd_dat0_i     ( sd_dat0_i     ),
    .qspi_dq0_i    ( qspi_dq0_i    ),
    .sd_power_on_i ( sd_power_on   ),
    .spi_target_i  ( spi_target    ),
    .spih_sd_o     ( spih_sd_o     ),
    .sd_sclk_o     ( sd_sclk_o     ),
    .sd_cmd_o      ( sd_cmd_o      ),
    .sd_dat3_o     ( sd_dat3_o     ),
    .sd_reset_o    ( sd_reset_o    ),
    .qspi_clk_o    ( qspi_clk_o    ),
    .qspi_cs_b_o   ( qspi_cs_b_o   )
  );

  board_ctrl_regs i_ctrl_regs (
    .soc_clk        ( soc_clk       ),
    .rst_n          ( sys_rst_n     ),
    .reg_req_i      ( reg_req_i     ),
    .reg_we_i       ( reg_we_i      ),
    .reg_addr_i     ( reg_addr_i    ),
    .reg_wdata_i    ( reg_wdata_i   ),
    .level_used_i   ( level_used    ),
    .sd_cd_i        ( sd_cd_i       ),
    .reg_rdata_o    ( reg_rdata_o   ),
    .reg_err_o      ( reg_err_o     ),
    .reg_valid_o    ( reg_valid_o   ),
    .fan_override_o ( fan_override  ),
    .fan_level_o    ( fan_level_reg ),
    .sd_power_on_o  ( sd_power_on   ),
    .spi_target_o   ( spi_target    )
  );

endmodule

`default_nettype wire

// ==== tb/board_top_checker.sv ====
/*
 * Bound assertions for the board wrapper
 * Reset state, rtc period, PWM duty, pad routing,
 * register response timing and error value
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module board_top_checker (
  input logic                      soc_clk,
  input logic                      rst_n,
  input logic                      reg_req_i,
  input logic                      reg_we_i,
  input board_reg_pkg::reg_addr_e  reg_addr_i,
  input logic [31:0]               reg_rdata_i,
  input logic                      reg_err_i,
  input logic                      reg_valid_i,
  input logic [3:0]                fan_sw_i,
  input logic                      fan_pwm_i,
  input logic                      fan_override_i,
  input board_io_pkg::fan_level_t  fan_level_reg_i,
  input board_io_pkg::fan_level_t  level_used_i,
  input logic                      rtc_i,
  input logic                      sd_power_on_i,
  input board_io_pkg::spi_target_e spi_target_i,
  input logic                      spih_sck_i,
  input logic                      spih_sck_en_i,
  input logic                      spih_csb_i,
  input logic                      spih_csb_en_i,
  input logic                      spih_sd_i,
  input logic                      spih_sd_en_i,
  input logic                      spih_miso_i,
  input logic                      sd_sclk_i,
  input logic                      sd_cmd_i,
  input logic                      sd_dat3_i,
  input logic                      sd_dat0_i,
  input logic                      sd_reset_i,
  input logic                      qspi_clk_i,
  input logic                      qspi_cs_b_i,
  input logic                      qspi_dq0_i
);

  import board_reg_pkg::*;
  import board_io_pkg::*;

  int unsigned fail_cnt = 0;
  logic        rtc_prev_q;
  logic [7:0]  since_tgl_q;
  fan_level_t  phase_q;
  fan_level_t  lvl_q;

  ////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////

  // Cycles since the last rtc edge
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_prev_q  <= 1'b0;
      since_tgl_q <= '0;
    end else begin
      rtc_prev_q  <= rtc_i;
      since_tgl_q <= (rtc_i != rtc_prev_q) ? 8'd1 : since_tgl_q + 8'd1;
    end
  end

  // PWM phase and level picked at each wrap
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= '0;
      lvl_q   <= '0;
    end else if (phase_q == fan_level_t'(`PWM_PERIOD - 1)) begin
      phase_q <= '0;
      lvl_q   <= fan_override_i ? fan_level_reg_i : fan_sw_i;
    end else begin
      phase_q <= phase_q + fan_level_t'(1);
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  a_reset_state: assert property (@(posedge soc_clk)
    !rst_n |-> !reg_valid_i && !fan_pwm_i && sd_reset_i && qspi_clk_i && qspi_cs_b_i)
    else begin
      fail_cnt++;
      $error("Outputs not at idle values during reset");
    end

  // An edge exactly every half period, none in between
  a_rtc_period: assert property (@(posedge soc_clk) disable iff (!rst_n)
    since_tgl_q <= 8'(`RTC_HALF_PERIOD) &&
    ((rtc_i != rtc_prev_q) == (since_tgl_q == 8'(`RTC_HALF_PERIOD))))
    else begin
      fail_cnt++;
      $error("rtc edge off its half period");
    end

  a_pwm_duty: assert property (@(posedge soc_clk) disable iff (!rst_n)
    fan_pwm_i == (phase_q < lvl_q) && level_used_i == lvl_q)
    else begin
      fail_cnt++;
      $error("Fan PWM output does not match the level in use");
    end

  a_pad_sd: assert property (@(posedge soc_clk) disable iff (!rst_n)
    spi_target_i == TARGET_SD |->
      sd_sclk_i == (!spih_sck_en_i || spih_sck_i) &&
      sd_dat3_i == (!spih_csb_en_i || spih_csb_i) &&
      sd_cmd_i == (!spih_sd_en_i || spih_sd_i) &&
      qspi_clk_i && qspi_cs_b_i && spih_miso_i == sd_dat0_i)
    else begin
      fail_cnt++;
      $error("Pad routing wrong for the SD target");
    end

  a_pad_flash: assert property (@(posedge soc_clk) disable iff (!rst_n)
    spi_target_i == TARGET_FLASH |->
      qspi_clk_i == (!spih_sck_en_i || spih_sck_i) &&
      qspi_cs_b_i == (!spih_csb_en_i || spih_csb_i) &&
      sd_sclk_i && sd_dat3_i && sd_cmd_i && spih_miso_i == qspi_dq0_i)
    else begin
      fail_cnt++;
      $error("Pad routing wrong for the flash target");
    end

  a_sd_reset: assert property (@(posedge soc_clk) disable iff (!rst_n)
    sd_reset_i == !sd_power_on_i)
    else begin
      fail_cnt++;
      $error("SD reset pin does not follow the power enable");
    end

  a_resp_timing: assert property (@(posedge soc_clk) disable iff (!rst_n)
    reg_valid_i == $past(reg_req_i))
    else begin
      fail_cnt++;
      $error("Register response not one cycle after the request");
    end

  a_err_resp: assert property (@(posedge soc_clk) disable iff (!rst_n)
    reg_req_i && (reg_addr_i == 2'd3 || (reg_we_i && reg_addr_i == ADDR_STATUS)) |=>
      reg_valid_i && reg_err_i && reg_rdata_i == `REG_ERR_VAL)
    else begin
      fail_cnt++;
      $error("Illegal register access without error response");
    end

  a_no_err: assert property (@(posedge soc_clk) disable iff (!rst_n)
    reg_req_i && reg_addr_i != 2'd3 && !(reg_we_i && reg_addr_i == ADDR_STATUS) |=>
      !reg_err_i)
    else begin
      fail_cnt++;
      $error("Error flag set on a legal register access");
    end

endmodule

bind board_top board_top_checker u_checker (
  .soc_clk         ( soc_clk       ),
  .rst_n           ( sys_rst_n     ),
  .reg_req_i       ( reg_req_i     ),
  .reg_we_i        ( reg_we_i      ),
  .reg_addr_i      ( reg_addr_i    ),
  .reg_rdata_i     ( reg_rdata_o   ),
  .reg_err_i       ( reg_err_o     ),
  .reg_valid_i     ( reg_valid_o   ),
  .fan_sw_i        ( fan_sw_i      ),
  .fan_pwm_i       ( fan_pwm_o     ),
  .fan_override_i  ( fan_override  ),
  .fan_level_reg_i ( fan_level_reg ),
  .level_used_i    ( level_used    ),
  .rtc_i           ( rtc_o         ),
  .sd_power_on_i   ( sd_power_on   ),
  .spi_target_i    ( spi_target    ),
  .spih_sck_i      ( spih_sck_i    ),
  .spih_sck_en_i   ( spih_sck_en_i ),
  .spih_csb_i      ( spih_csb_i    ),
  .spih_csb_en_i   ( spih_csb_en_i ),
  .spih_sd_i       ( spih_sd_i     ),
  .spih_sd_en_i    ( spih_sd_en_i  ),
  .spih_miso_i     ( spih_sd_o     ),
  .sd_sclk_i       ( sd_sclk_o     ),
  .sd_cmd_i        ( sd_cmd_o      ),
  .sd_dat3_i       ( sd_dat3_o     ),
  .sd_dat0_i       ( sd_dat0_i     ),
  .sd_reset_i      ( sd_reset_o    ),
  .qspi_clk_i      ( qspi_clk_o    ),
  .qspi_cs_b_i     ( qspi_cs_b_o   ),
  .qspi_dq0_i      ( qspi_dq0_i    )
);

`default_nettype wire

// ==== tb/board_top_tb.sv ====
/*
 * Testbench for the board wrapper
 * Clock and reset, register bus tasks,
 * fan PWM, pad routing and error responses
 */
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module board_top_tb;

  import board_reg_pkg::*;

  logic        soc_clk;
  logic        rst_n;
  logic        testmode;
  logic [3:0]  fan_sw;
  logic        fan_pwm;
  logic        spih_sck;
  logic        spih_sck_en;
  logic        spih_csb;
  logic        spih_csb_en;
  logic        spih_sd;
  logic        spih_sd_en;
  logic        spih_miso;
  logic        sd_cd;
  logic        sd_sclk;
  logic        sd_cmd;
  logic        sd_dat3;
  logic        sd_dat0;
  logic        sd_reset;
  logic        qspi_clk;
  logic        qspi_cs_b;
  logic        qspi_dq0;
  logic        reg_req;
  logic        reg_we;
  reg_addr_e   reg_addr;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic        reg_err;
  logic        reg_valid;
  logic        rtc;

  int          err_cnt = 0;
  logic [31:0] rng_state = 32'h6b39;

  board_top dut (
    .soc_clk       ( soc_clk     ),
    .rst_n         ( rst_n       ),
    .testmode_i    ( testmode    ),
    .fan_sw_i      ( fan_sw      ),
    .fan_pwm_o     ( fan_pwm     ),
    .spih_sck_i    ( spih_sck    ),
    .spih_sck_en_i ( spih_sck_en ),
    .spih_csb_i    ( spih_csb    ),
    .spih_csb_en_i ( spih_csb_en ),
    .spih_sd_i     ( spih_sd     ),
    .spih_sd_en_i  ( spih_sd_en  ),
    .spih_sd_o     ( spih_miso   ),
    .sd_cd_i       ( sd_cd       ),
    .sd_sclk_o     ( sd_sclk     ),
    .sd_cmd_o      ( sd_cmd      ),
    .sd_dat3_o     ( sd_dat3     ),
    .sd_dat0_i     ( sd_dat0     ),
    .sd_reset_o    ( sd_reset    ),
    .qspi_clk_o    ( qspi_clk    ),
    .qspi_cs_b_o   ( qspi_cs_b   ),
    .qspi_dq0_i    ( qspi_dq0    ),
    .reg_req_i     ( reg_req     ),
    .reg_we_i      ( reg_we      ),
    .reg_addr_i    ( reg_addr    ),
    .reg_wdata_i   ( reg_wdata   ),
    .reg_rdata_o   ( reg_rdata   ),
    .reg_err_o     ( reg_err     ),
    .reg_valid_o   ( reg_valid   ),
    .rtc_o         ( rtc         )
  );

  initial begin
    soc_clk = 1'b0;
    forever #10 soc_clk = ~soc_clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // One strobe, then wait for the valid pulse
  task automatic bus_access(input logic we, input logic [1:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waited;
    @(posedge soc_clk);
    reg_req   <= 1'b1;
    reg_we    <= we;
    reg_addr  <= reg_addr_e'(addr);
    reg_wdata <= wdata;
    @(posedge soc_clk);
    reg_req <= 1'b0;
    waited = 0;
    @(negedge soc_clk);
    while (!reg_valid && waited < 10) begin
      @(negedge soc_clk);
      waited++;
    end
    if (!reg_valid) begin
      err_cnt++;
      $display("Timeout: no register response for address %0d", addr);
    end
    rdata = reg_rdata;
    err   = reg_err;
  endtask

  task automatic reg_write(input string name, input logic [1:0] addr,
                           input logic [31:0] wdata, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, addr, wdata, rdata, err);
    check_val({name, "_err"}, 32'(exp_err), 32'(err));
    if (exp_err) check_val({name, "_data"}, `REG_ERR_VAL, rdata);
  endtask

  task automatic reg_read(input string name, input logic [1:0] addr,
                          input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b0, addr, 32'd0, rdata, err);
    check_val({name, "_err"}, 32'(exp_err), 32'(err));
    check_val(name, exp_data, rdata);
  endtask

  task automatic wait_rtc_toggles(input int n);
    int   seen;
    int   cycles;
    logic last;
    seen   = 0;
    cycles = 0;
    last   = rtc;
    while (seen < n && cycles < (n + 1) * `RTC_HALF_PERIOD) begin
      @(negedge soc_clk);
      cycles++;
      if (rtc !== last) begin
        seen++;
        last = rtc;
      end
    end
    if (seen < n) begin
      err_cnt++;
      $display("Timeout: rtc clock stopped toggling");
    end
  endtask

  // High cycles in any window of one PWM period
  task automatic pwm_highs(output int highs);
    highs = 0;
    repeat (`PWM_PERIOD) begin
      @(negedge soc_clk);
      if (fan_pwm) highs++;
    end
  endtask

  // Host clock enabled and low, so only the selected target's clock drops
  // Compared as sd_sclk, qspi_clk, sd_reset
  task automatic check_pad_pins(input string name, input logic [2:0] exp);
    @(posedge soc_clk);
    spih_sck_en <= 1'b1;
    spih_sck    <= 1'b0;
    @(negedge soc_clk);
    check_val(name, 32'(exp), 32'({sd_sclk, qspi_clk, sd_reset}));
  endtask

  task automatic drive_spi_random(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = next_random();
      @(posedge soc_clk);
      spih_sck    <= r[0];
      spih_sck_en <= r[1];
      spih_csb    <= r[2];
      spih_csb_en <= r[3];
      spih_sd     <= r[4];
      spih_sd_en  <= r[5];
      sd_dat0     <= r[6];
      qspi_dq0    <= r[7];
    end
    @(posedge soc_clk);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [3:0]  lvl;
    int          highs;
    int          total;
    rst_n       = 1'b0;
    testmode    = 1'b0;
    fan_sw      = 4'd0;
    spih_sck    = 1'b0;
    spih_sck_en = 1'b0;
    spih_csb    = 1'b1;
    spih_csb_en = 1'b0;
    spih_sd     = 1'b0;
    spih_sd_en  = 1'b0;
    sd_cd       = 1'b1;
    sd_dat0     = 1'b0;
    qspi_dq0    = 1'b0;
    reg_req     = 1'b0;
    reg_we      = 1'b0;
    reg_addr    = ADDR_FAN;
    reg_wdata   = 32'd0;

    repeat (10) @(posedge soc_clk);
    rst_n <= 1'b1;
    repeat (`RST_SYNC_STAGES + 1) @(posedge soc_clk);
    @(negedge soc_clk);
    // valid, pwm, sd_reset, qspi_cs_b, qspi_clk
    check_val("reset_state", 32'h7, 32'({reg_valid, fan_pwm, sd_reset, qspi_cs_b, qspi_clk}));

    wait_rtc_toggles(3);

    // Switch levels with the override off
    for (int i = 0; i < 4; i++) begin
      r   = next_random();
      lvl = (i == 0) ? 4'd0 : (i == 1) ? 4'd7 : (i == 2) ? 4'd15 : r[3:0];
      @(posedge soc_clk);
      fan_sw <= lvl;
      repeat (2 * `PWM_PERIOD) @(posedge soc_clk);
      pwm_highs(highs);
      check_val("pwm_switch", 32'(lvl), 32'(highs));
    end

    r   = next_random();
    lvl = r[7:4];
    if (lvl == fan_sw) lvl = ~lvl;
    reg_write("fan_override", ADDR_FAN, {r[31:5], 1'b1, lvl}, 1'b0);
    reg_read("fan_readback", ADDR_FAN, {27'd0, 1'b1, lvl}, 1'b0);
    repeat (2 * `PWM_PERIOD) @(posedge soc_clk);
    pwm_highs(highs);
    check_val("pwm_override", 32'(lvl), 32'(highs));
    reg_read("status_level", ADDR_STATUS, {27'd0, sd_cd, lvl}, 1'b0);

    // SD target with card power on
    r = next_random();
    reg_write("pad_sd", ADDR_PAD, {r[31:2], 2'b10}, 1'b0);
    reg_read("pad_sd_readback", ADDR_PAD, 32'h2, 1'b0);
    check_pad_pins("pad_sd_pins", 3'b010);
    drive_spi_random(40);

    r = next_random();
    reg_write("pad_flash", ADDR_PAD, {r[31:2], 2'b01}, 1'b0);
    reg_read("pad_flash_readback", ADDR_PAD, 32'h1, 1'b0);
    check_pad_pins("pad_flash_pins", 3'b101);
    drive_spi_random(40);

    reg_read("unmapped_read", 2'd3, `REG_ERR_VAL, 1'b1);
    reg_write("unmapped_write", 2'd3, next_random(), 1'b1);
    reg_write("status_write", ADDR_STATUS, next_random(), 1'b1);
    reg_read("fan_unchanged", ADDR_FAN, {27'd0, 1'b1, lvl}, 1'b0);
    reg_read("pad_unchanged", ADDR_PAD, 32'h1, 1'b0);

    // Back to back reads, one strobe per cycle
    for (int i = 0; i < 6; i++) begin
      r = next_random();
      @(posedge soc_clk);
      reg_req  <= 1'b1;
      reg_we   <= 1'b0;
      reg_addr <= reg_addr_e'(r[1:0]);
    end
    @(posedge soc_clk);
    reg_req <= 1'b0;
    repeat (4) @(posedge soc_clk);

    total = err_cnt + int'(dut.u_checker.fail_cnt);
    $display("Errors: %0d testbench checks, %0d assertions", err_cnt, dut.u_checker.fail_cnt);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== board_top.f ====
+incdir+rtl
rtl/board_reg_pkg.sv
rtl/board_io_pkg.sv
rtl/board_rstgen.sv
rtl/board_rtc_div.sv
rtl/board_fan_pwm.sv
rtl/board_pad_adapt.sv
rtl/board_ctrl_regs.sv
rtl/board_top.sv
tb/board_top_checker.sv
tb/board_top_tb.sv

// ==== Makefile ====
# Verilator simulation of the board wrapper

TOP   := board_top_tb
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Mdir $(BUILD) --top-module $(TOP) -f board_top.f
	./$(BUILD)/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -qx "Simulation finished: PASS" sim.log; then \
		echo "Result: passed"; \
	else \
		echo "Result: failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) sim.log
